/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f uart_cmd_bridge.f \
  --top-module uart_cmd_bridge_tb -o sim_tb || exit 1

out=$(./obj_dir/sim_tb 2>&1)
echo "$out"

echo "$out" | grep -q "PASS: all tests" && echo "simulation passed" && exit 0 || exit 1

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // released on a falling edge after two cycles
  end

endmodule

/* uart_cmd_bridge.f */
uart_cmd_pkg.sv
uart_tx.sv
uart_rx.sv
uart_cmd_ctrl.sv
uart_cmd_bridge.sv
tb_clock.sv
uart_peer_model.sv
uart_cmd_bridge_tb.sv

/* uart_cmd_bridge.sv */
`timescale 1ns/1ns

module uart_cmd_bridge
  import uart_cmd_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  cmd_t cmd,
  input  logic cmd_valid,
  output logic cmd_ready,
  output rsp_t rsp,
  output logic rsp_valid,
  input  logic rsp_ready,
  input  logic rx,
  output logic tx
);

  logic [7:0] tx_byte;
  logic       tx_valid;
  logic       tx_ready;
  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       rx_err;
  logic       rx_start;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .rx_err    (rx_err),
    .rx_start  (rx_start)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  uart_rx u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_err   (rx_err),
    .rx_start (rx_start)
  );

endmodule

/* uart_cmd_bridge_tb.sv */
`timescale 1ns/1ns

module uart_cmd_bridge_tb
  import uart_cmd_pkg::*;
();

  localparam int N_WRITES       = 6;
  localparam int N_CMDS         = 2 * N_WRITES + 4;
  localparam int CMD_BUDGET     = 3 * FRAME_BITS * CLKS_PER_BIT + RSP_TIMEOUT_CLKS + 2 * GAP_CLKS;
  localparam int TIMEOUT_CYCLES = N_CMDS * CMD_BUDGET * 2;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd;
  logic       cmd_valid;
  logic       cmd_ready;
  rsp_t       rsp;
  logic       rsp_valid;
  logic       rsp_ready;
  logic       serial_to_peer;
  logic       serial_to_dut;
  logic       corrupt_parity;
  logic       mute;
  logic       got_byte;
  logic [7:0] got_data;
  logic       got_par_ok;
  logic       got_stop_ok;
  logic [7:0] sb_mem [0:127];
  logic [7:0] seen_q [$];
  logic [6:0] wr_addr [N_WRITES];
  logic       expect_rsp;
  int         cycle_cnt = 0;
  integer     seed;
  rsp_t       got;

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));

  uart_cmd_bridge dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rx        (serial_to_dut),
    .tx        (serial_to_peer)
  );

  uart_peer_model peer (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx             (serial_to_peer),
    .corrupt_parity (corrupt_parity),
    .mute           (mute),
    .tx             (serial_to_dut),
    .got_byte       (got_byte),
    .got_data       (got_data),
    .got_par_ok     (got_par_ok),
    .got_stop_ok    (got_stop_ok)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string what);
    abort_run($sformatf("MISMATCH at %0t ns: %s", $time, what));
  endtask

  // starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_cmd(input cmd_t c);
    cmd       = c;
    cmd_valid = 1'b1;
    while (!cmd_ready)
      @(negedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic do_write(input logic [6:0] a, input logic [7:0] d);
    int   base;
    cmd_t c;
    base    = seen_q.size();
    c.write = 1'b1;
    c.addr  = a;
    c.data  = d;
    send_cmd(c);
    while (!cmd_ready)
      @(negedge clk);
    assert (seen_q.size() == base + 2)
      else report_mismatch($sformatf("write: %0d frames seen", seen_q.size() - base));
    assert (seen_q[base] == {1'b1, a} && seen_q[base + 1] == d)
      else report_mismatch($sformatf("write frames %02h %02h, expected %02h %02h",
                                     seen_q[base], seen_q[base + 1], {1'b1, a}, d));
    sb_mem[a] = d;
  endtask

  task automatic do_read(input logic [6:0] a, output rsp_t r);
    int          base;
    int          hold;
    logic [31:0] rnd;
    cmd_t        c;
    base       = seen_q.size();
    c.write    = 1'b0;
    c.addr     = a;
    c.data     = 8'h00;
    expect_rsp = 1'b1;
    send_cmd(c);
    while (!rsp_valid)
      @(negedge clk);
    assert (seen_q.size() == base + 1 && seen_q[base] == {1'b0, a})
      else report_mismatch($sformatf("read address frame wrong for address %02h", a));
    r    = rsp;
    rnd  = $random(seed);
    hold = 1 + int'(rnd[3:0]);
    repeat (hold)
    begin
      @(negedge clk);
      assert (rsp_valid && rsp == r && !cmd_ready)
        else report_mismatch("response changed or cmd_ready rose while rsp_ready was low");
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    assert (!rsp_valid) else report_mismatch("rsp_valid still high after the handshake");
    expect_rsp = 1'b0;
  endtask

  always @(posedge clk)
  begin
    if (got_byte)
      seen_q.push_back(got_data);
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
      abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  assert property (@(posedge clk) disable iff (!rst_n) got_byte |-> (got_par_ok && got_stop_ok))
    else report_mismatch("peer decoded a frame with even parity or a low stop bit");

  assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> (expect_rsp && !cmd_ready))
    else report_mismatch("rsp_valid outside a read, or cmd_ready high during a response");

  initial
  begin
    logic [31:0] r;
    seed           = 69;
    cmd            = '0;
    cmd_valid      = 1'b0;
    rsp_ready      = 1'b0;
    corrupt_parity = 1'b0;
    mute           = 1'b0;
    expect_rsp     = 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    assert (serial_to_peer && cmd_ready && !rsp_valid)
      else report_mismatch("reset state of tx, cmd_ready or rsp_valid");
    for (int i = 0; i < 128; i++)
      sb_mem[i] = peer.mem[i];

    for (int i = 0; i < N_WRITES; i++)
    begin
      r          = $random(seed);
      wr_addr[i] = r[6:0];
      do_write(r[6:0], r[15:8]);
    end
    for (int i = 0; i < N_WRITES; i++)
    begin
      do_read(wr_addr[i], got);
      assert (got.data == sb_mem[wr_addr[i]] && !got.frame_err && !got.timeout)
        else report_mismatch($sformatf("read %02h gave %02h fe=%b to=%b, expected %02h",
                                       wr_addr[i], got.data, got.frame_err, got.timeout,
                                       sb_mem[wr_addr[i]]));
    end

    corrupt_parity = 1'b1;  // reply arrives with even parity
    do_read(wr_addr[0], got);
    corrupt_parity = 1'b0;
    assert (got.frame_err && !got.timeout)
      else report_mismatch("bad reply parity not flagged as frame_err");

    mute = 1'b1;
    do_read(wr_addr[1], got);
    mute = 1'b0;
    assert (got.timeout && !got.frame_err && got.data == 8'h00)
      else report_mismatch($sformatf("silent peer gave data %02h to=%b", got.data, got.timeout));

    r = $random(seed);
    do_write(r[6:0], r[15:8]);
    do_read(r[6:0], got);
    assert (got.data == r[15:8] && !got.frame_err && !got.timeout)
      else report_mismatch($sformatf("read after timeout gave %02h, expected %02h",
                                     got.data, r[15:8]));

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* uart_cmd_ctrl.sv */
`timescale 1ns/1ns

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  output rsp_t       rsp,
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output logic [7:0] tx_byte,
  output logic       tx_valid,
  input  logic       tx_ready,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  input  logic       rx_err,
  input  logic       rx_start
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,
    S_ADDR_WAIT,
    S_GAP,
    S_DATA,
    S_DATA_WAIT,
    S_REPLY,
    S_RECV
  } ctrl_state_t;

  ctrl_state_t           state_q;
  ctrl_state_t           state_d;
  cmd_t                  cmd_q;
  logic [WAIT_CNT_W-1:0] cnt;
  logic                  resp_q;  // response held for the host
  logic                  gap_done;
  logic                  timed_out;

  assign cmd_ready = (state_q == S_IDLE) & ~resp_q;
  assign rsp_valid = resp_q;
  assign tx_valid  = (state_q == S_ADDR) | (state_q == S_DATA);
  assign tx_byte   = (state_q == S_DATA) ? cmd_q.data : {cmd_q.write, cmd_q.addr};

  assign gap_done  = cnt == WAIT_CNT_W'(GAP_CLKS - 1);
  assign timed_out = cnt == WAIT_CNT_W'(RSP_TIMEOUT_CLKS - 1);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:      if (cmd_valid && !resp_q) state_d = S_ADDR;
      S_ADDR:      if (tx_ready) state_d = S_ADDR_WAIT;
      S_ADDR_WAIT: if (tx_ready) state_d = S_GAP;  // ready again once the frame is out
      S_GAP:
      begin
        if (gap_done)
        begin
          state_d = cmd_q.write ? S_DATA : S_REPLY;
        end
      end
      S_DATA:      if (tx_ready) state_d = S_DATA_WAIT;
      S_DATA_WAIT: if (tx_ready) state_d = S_IDLE;
      S_REPLY:
      begin
        if (rx_start)
        begin
          state_d = S_RECV;
        end
        else if (timed_out)
        begin
          state_d = S_IDLE;
        end
      end
      S_RECV:      if (rx_valid) state_d = S_IDLE;
      default:     state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= S_IDLE;
      cnt     <= '0;
      resp_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (state_d != state_q)
      begin
        cnt <= '0;
      end
      else if (state_q == S_GAP || state_q == S_REPLY)
      begin
        cnt <= cnt + 1'b1;
      end
      if (resp_q && rsp_ready)
      begin
        resp_q <= 1'b0;
      end
      else if ((state_q == S_RECV && rx_valid) || (state_q == S_REPLY && state_d == S_IDLE))
      begin
        resp_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == S_IDLE && state_d == S_ADDR)
    begin
      cmd_q <= cmd;
    end
    if (state_q == S_RECV && rx_valid)
    begin
      rsp <= '{data: rx_byte, frame_err: rx_err, timeout: 1'b0};
    end
    else if (state_q == S_REPLY && state_d == S_IDLE)
    begin
      rsp <= '{data: 8'h00, frame_err: 1'b0, timeout: 1'b1};  // no start bit in time
    end
  end

endmodule

/* uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // serial timing counted in clk cycles
  localparam int CLKS_PER_BIT     = 16;  // 434 for 50 MHz at 115200 baud
  localparam int FRAME_BITS       = 11;  // start, 8 data, parity, stop
  localparam int GAP_CLKS         = 100;
  localparam int RSP_TIMEOUT_CLKS = 24 * CLKS_PER_BIT;

  localparam int HALF_BIT   = CLKS_PER_BIT / 2;
  localparam int BIT_CNT_W  = $clog2(CLKS_PER_BIT);
  localparam int IDX_W      = $clog2(FRAME_BITS);
  localparam int WAIT_CNT_W = $clog2(RSP_TIMEOUT_CLKS);

  typedef struct packed {
    logic       write;  // 1 for write, 0 for read
    logic [6:0] addr;
    logic [7:0] data;   // don't care on a read
  } cmd_t;

  typedef struct packed {
    logic [7:0] data;       // zero when the reply timed out
    logic       frame_err;  // bad parity or low stop bit
    logic       timeout;
  } rsp_t;

  // parity bit that makes the data plus parity hold an odd count of ones
  function automatic logic odd_parity(input logic [7:0] d);
    return ~^d;
  endfunction

endpackage

/* uart_peer_model.sv */
`timescale 1ns/1ns

module uart_peer_model
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       corrupt_parity,
  input  logic       mute,
  output logic       tx,
  output logic       got_byte,
  output logic [7:0] got_data,
  output logic       got_par_ok,
  output logic       got_stop_ok
);

  localparam int REPLY_DELAY = GAP_CLKS + 3 * CLKS_PER_BIT;  // past the bridge's gap

  logic [7:0] mem [0:127];
  logic       line_q = 1'b1;
  logic       wr_pend;
  logic [6:0] pend_addr;

  assign tx = line_q;

  task automatic send_reply(input logic [7:0] d);
    logic [10:0] frame;
    frame = {1'b1, ~(^d) ^ corrupt_parity, d, 1'b0};
    repeat (REPLY_DELAY) @(posedge clk);
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      line_q <= frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  always
  begin : decode
    logic [7:0] b;
    logic       p;
    logic       s;
    @(posedge clk);
    if (!rst_n)
    begin
      line_q   <= 1'b1;
      got_byte <= 1'b0;
      wr_pend = 1'b0;
      for (int i = 0; i < 128; i++)
        mem[i] = 8'(i * 37) ^ 8'h5a;  // odd multiplier so every address bit counts
    end
    else if (!rx)
    begin
      repeat (HALF_BIT) @(posedge clk);
      if (!rx)
      begin
        for (int i = 0; i < 8; i++)
        begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          b[i] = rx;
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        p = rx;
        repeat (CLKS_PER_BIT) @(posedge clk);
        s = rx;
        got_data    <= b;
        got_par_ok  <= ^{b, p};
        got_stop_ok <= s;
        got_byte    <= 1'b1;
        @(posedge clk);
        got_byte <= 1'b0;
        if (wr_pend)
        begin
          mem[pend_addr] = b;  // second byte of a write
          wr_pend = 1'b0;
        end
        else if (b[7])
        begin
          wr_pend   = 1'b1;
          pend_addr = b[6:0];
        end
        else if (!mute)
        begin
          send_reply(mem[b[6:0]]);
        end
      end
    end
  end

endmodule

/* uart_rx.sv */
`timescale 1ns/1ns

module uart_rx
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       rx_err,
  output logic       rx_start
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS
  } rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [IDX_W-1:0]     bit_idx;  // 0..7 data, 8 parity, 9 stop
  logic                 par_bit;
  logic                 fall;
  logic                 sample;

  assign fall   = rx_prev & ~rx_sync;
  assign sample = (state == RX_BITS) && (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
      rx_start <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      rx_start <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          clk_cnt <= '0;
          if (fall)
          begin
            state <= RX_START;
          end
        end
        RX_START:
        begin
          if (clk_cnt == BIT_CNT_W'(HALF_BIT - 1))
          begin
            clk_cnt <= '0;
            bit_idx <= '0;
            if (!rx_sync)
            begin
              rx_start <= 1'b1;
              state    <= RX_BITS;
            end
            else
            begin
              state <= RX_IDLE;  // the line is already back high so this was a glitch
            end
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_BITS:
        begin
          if (sample)
          begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_W'(FRAME_BITS - 2))
            begin
              rx_valid <= 1'b1;
              rx_err   <= ~rx_sync | (par_bit != odd_parity(rx_byte));
              state    <= RX_IDLE;
            end
          end
          else
          begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // the lsb arrives first so bits shift in from the top
  always_ff @(posedge clk)
  begin
    if (sample && bit_idx < IDX_W'(8))
    begin
      rx_byte <= {rx_sync, rx_byte[7:1]};
    end
    else if (sample && bit_idx == IDX_W'(8))
    begin
      par_bit <= rx_sync;
    end
  end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ns

module uart_tx
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_byte,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic       tx
);

  logic                 busy;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [IDX_W-1:0]     bit_cnt;
  logic [9:0]           shift_q;  // holds stop, parity and data while start goes straight to tx
  logic                 load;
  logic                 bit_end;

  assign tx_ready = ~busy;
  assign load     = tx_valid & ~busy;
  assign bit_end  = busy & (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (load)
    begin
      busy    <= 1'b1;
      tx      <= 1'b0;  // start bit
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      tx      <= shift_q[0];  // ones shifted in leave the line idle after the stop bit
      if (bit_cnt == IDX_W'(FRAME_BITS - 1))
      begin
        busy <= 1'b0;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
    else if (busy)
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shift_q <= {1'b1, odd_parity(tx_byte), tx_byte};
    end
    else if (bit_end)
    begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

endmodule
